//--- src/blend_settings.svh
`ifndef BLEND_SETTINGS_SVH
`define BLEND_SETTINGS_SVH

////////////////////
// Pixel formats
////////////////////

// Layer 0 is ARGB8888, alpha in the top byte then R, G, B
`define BLEND_BASE_WIDTH 32

// Grey overlay level
`define BLEND_OVL_WIDTH 8

// Output pixel is RGB888
`define BLEND_OUT_WIDTH 24

////////////////////
// Frame indexing
////////////////////

`define BLEND_WBITS 12
`define BLEND_HBITS 12

`endif

//--- src/blend_pkg.sv
`default_nettype none

package blend_pkg;

	////////////////////
	// Window tracker
	////////////////////

	// Sync drops pixels until a frame start, run follows the raster
	typedef enum logic {
		WIN_SYNC = 1'b0,
		WIN_RUN  = 1'b1
	} win_state_t;

	////////////////////
	// Overlay priority
	////////////////////

	// Which grey layer wins where both windows overlap
	typedef enum logic {
		ORDER_1_OVER_2 = 1'b0,
		ORDER_2_OVER_1 = 1'b1
	} ovl_order_t;

endpackage

`default_nettype wire

//--- src/frame_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_settings.svh"

module frame_scanner (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    advance,
	input  logic [`BLEND_WBITS-1:0] frame_width,
	input  logic [`BLEND_HBITS-1:0] frame_height,
	output logic [`BLEND_WBITS-1:0] col,
	output logic [`BLEND_HBITS-1:0] row,
	output logic                    frame_first,
	output logic                    line_last
);

	logic [`BLEND_WBITS-1:0] last_col;
	logic [`BLEND_HBITS-1:0] last_row;

	assign last_col = frame_width - 1'b1;
	assign last_row = frame_height - 1'b1;

	// Raster position of the next output beat
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col <= '0;
			row <= '0;
		end else if (advance) begin
			if (col != last_col) begin
				col <= col + 1'b1;
			end else begin
				col <= '0;
				// Wrap to the top after the bottom line
				if (row != last_row) begin
					row <= row + 1'b1;
				end else begin
					row <= '0;
				end
			end
		end
	end

	assign frame_first = (col == '0) && (row == '0);
	assign line_last   = (col == last_col);

endmodule

`default_nettype wire

//--- src/layer_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_settings.svh"

module layer_window
	import blend_pkg::*;
(
	input  logic                         clk,
	input  logic                         resetn,
	input  logic                         advance,
	input  logic [`BLEND_WBITS-1:0]      col,
	input  logic [`BLEND_HBITS-1:0]      row,
	input  logic [`BLEND_WBITS-1:0]      win_left,
	input  logic [`BLEND_HBITS-1:0]      win_top,
	input  logic [`BLEND_WBITS-1:0]      win_width,
	input  logic [`BLEND_HBITS-1:0]      win_height,
	input  logic                         s_valid,
	input  logic [`BLEND_BASE_WIDTH-1:0] s_data,
	input  logic                         s_user,
	input  logic                         s_last,
	output logic                         s_ready,
	output logic                         need,
	output logic                         pix_valid,
	output logic [`BLEND_BASE_WIDTH-1:0] pix_data
);

	win_state_t state;
	logic live;
	logic pix_last;
	logic accept;
	logic consume;
	logic frame_done;
	logic in_cols;
	logic in_rows;
	logic bottom_row;
	// One bit wider so a window touching the index limit does not wrap
	logic [`BLEND_WBITS:0] col_end;
	logic [`BLEND_HBITS:0] row_end;

	////////////////////
	// Window hit test
	////////////////////

	assign col_end = {1'b0, win_left} + {1'b0, win_width};
	assign row_end = {1'b0, win_top} + {1'b0, win_height};

	assign in_cols    = (col >= win_left) && ({1'b0, col} < col_end);
	assign in_rows    = (row >= win_top) && ({1'b0, row} < row_end);
	assign need       = in_cols && in_rows;
	assign bottom_row = ({1'b0, row} == row_end - 1'b1);

	////////////////////
	// Handshake
	////////////////////

	// Held pixel leaves when the raster passes over it
	assign consume    = advance && need;
	assign frame_done = consume && pix_last && bottom_row;

	assign s_ready = live && (!pix_valid || consume);
	assign accept  = s_valid && s_ready;

	// Keeps ready low through the reset cycle
	always_ff @(posedge clk) begin
		if (!resetn) begin
			live <= 1'b0;
		end else begin
			live <= 1'b1;
		end
	end

	////////////////////
	// Tracker FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= WIN_SYNC;
			pix_valid <= 1'b0;
		end else begin
			case (state)
				WIN_SYNC: begin
					// Everything before a frame start is dropped
					if (accept && s_user) begin
						state     <= WIN_RUN;
						pix_valid <= 1'b1;
					end
				end
				WIN_RUN: begin
					if (accept && (s_user || !frame_done)) begin
						pix_valid <= 1'b1;
					end else if (consume) begin
						pix_valid <= 1'b0;
					end
					// Last window pixel gone, wait for the next frame start
					if (frame_done && !(accept && s_user)) begin
						state <= WIN_SYNC;
					end
				end
				default: begin
					state     <= WIN_SYNC;
					pix_valid <= 1'b0;
				end
			endcase
		end
	end

	// Payload only, qualified by pix_valid
	always_ff @(posedge clk) begin
		if (accept) begin
			pix_data <= s_data;
			pix_last <= s_last;
		end
	end

endmodule

`default_nettype wire

//--- src/alpha_mixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_settings.svh"

module alpha_mixer
	import blend_pkg::*;
(
	input  logic                         clk,
	input  logic                         resetn,
	input  logic                         advance,
	input  ovl_order_t                   order,
	input  logic                         frame_first,
	input  logic                         line_last,
	input  logic [`BLEND_BASE_WIDTH-1:0] base_data,
	input  logic                         ovl1_need,
	input  logic                         ovl2_need,
	input  logic [`BLEND_OVL_WIDTH-1:0]  ovl1_data,
	input  logic [`BLEND_OVL_WIDTH-1:0]  ovl2_data,
	input  logic                         out_ready,
	output logic                         out_valid,
	output logic                         out_user,
	output logic                         out_last,
	output logic [`BLEND_OUT_WIDTH-1:0]  out_data
);

	logic [7:0] alpha;
	logic [`BLEND_OVL_WIDTH-1:0] grey;
	logic any_ovl;
	logic [`BLEND_OUT_WIDTH-1:0] mixed;

	// Move channel c toward grey g by a/256 of the distance
	function automatic logic [7:0] blend_channel(
		input logic [7:0] c,
		input logic [7:0] g,
		input logic [7:0] a
	);
		logic [7:0]  diff;
		logic [15:0] prod;
		if (g > c) begin
			diff = g - c;
			prod = diff * a;
			return c + prod[15:8];
		end else begin
			diff = c - g;
			prod = diff * a;
			return c - prod[15:8];
		end
	endfunction

	////////////////////
	// Overlay select
	////////////////////

	assign any_ovl = ovl1_need || ovl2_need;

	always_comb begin
		if (ovl1_need && ovl2_need) begin
			grey = (order == ORDER_1_OVER_2) ? ovl1_data : ovl2_data;
		end else if (ovl1_need) begin
			grey = ovl1_data;
		end else begin
			grey = ovl2_data;
		end
	end

	////////////////////
	// Blend
	////////////////////

	assign alpha = base_data[`BLEND_BASE_WIDTH-1 -: 8];

	always_comb begin
		if (any_ovl) begin
			mixed[23:16] = blend_channel(base_data[23:16], grey, alpha);
			mixed[15:8]  = blend_channel(base_data[15:8], grey, alpha);
			mixed[7:0]   = blend_channel(base_data[7:0], grey, alpha);
		end else begin
			mixed = base_data[`BLEND_OUT_WIDTH-1:0];
		end
	end

	////////////////////
	// Output stage
	////////////////////

	// A beat stays up until the sink takes it with no new one behind
	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			out_user  <= 1'b0;
			out_last  <= 1'b0;
		end else if (advance) begin
			out_valid <= 1'b1;
			out_user  <= frame_first;
			out_last  <= line_last;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			out_data <= mixed;
		end
	end

endmodule

`default_nettype wire

//--- src/layer_blender.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_settings.svh"

module layer_blender
	import blend_pkg::*;
(
	input  logic                         clk,
	input  logic                         resetn,
	input  ovl_order_t                   order,
	input  logic [`BLEND_WBITS-1:0]      frame_width,
	input  logic [`BLEND_HBITS-1:0]      frame_height,

	input  logic                         s0_valid,
	input  logic [`BLEND_BASE_WIDTH-1:0] s0_data,
	input  logic                         s0_user,
	input  logic                         s0_last,
	output logic                         s0_ready,
	input  logic [`BLEND_WBITS-1:0]      s0_left,
	input  logic [`BLEND_HBITS-1:0]      s0_top,
	input  logic [`BLEND_WBITS-1:0]      s0_width,
	input  logic [`BLEND_HBITS-1:0]      s0_height,

	input  logic                         s1_valid,
	input  logic [`BLEND_OVL_WIDTH-1:0]  s1_data,
	input  logic                         s1_user,
	input  logic                         s1_last,
	output logic                         s1_ready,
	input  logic [`BLEND_WBITS-1:0]      s1_left,
	input  logic [`BLEND_HBITS-1:0]      s1_top,
	input  logic [`BLEND_WBITS-1:0]      s1_width,
	input  logic [`BLEND_HBITS-1:0]      s1_height,

	input  logic                         s2_valid,
	input  logic [`BLEND_OVL_WIDTH-1:0]  s2_data,
	input  logic                         s2_user,
	input  logic                         s2_last,
	output logic                         s2_ready,
	input  logic [`BLEND_WBITS-1:0]      s2_left,
	input  logic [`BLEND_HBITS-1:0]      s2_top,
	input  logic [`BLEND_WBITS-1:0]      s2_width,
	input  logic [`BLEND_HBITS-1:0]      s2_height,

	output logic                         out_valid,
	output logic [`BLEND_OUT_WIDTH-1:0]  out_data,
	output logic                         out_user,
	output logic                         out_last,
	input  logic                         out_ready
);

	localparam int PAD = `BLEND_BASE_WIDTH - `BLEND_OVL_WIDTH;

	logic [`BLEND_WBITS-1:0] col;
	logic [`BLEND_HBITS-1:0] row;
	logic frame_first;
	logic line_last;
	logic advance;
	logic need0;
	logic need1;
	logic need2;
	logic pix_valid0;
	logic pix_valid1;
	logic pix_valid2;
	logic [`BLEND_BASE_WIDTH-1:0] pix0;
	logic [`BLEND_BASE_WIDTH-1:0] pix1;
	logic [`BLEND_BASE_WIDTH-1:0] pix2;

	// Step the raster once every needed layer has its pixel and the sink is open
	assign advance = (!need0 || pix_valid0)
		&& (!need1 || pix_valid1)
		&& (!need2 || pix_valid2)
		&& out_ready;

	frame_scanner scanner (
		.clk         (clk),
		.resetn      (resetn),
		.advance     (advance),
		.frame_width (frame_width),
		.frame_height(frame_height),
		.col         (col),
		.row         (row),
		.frame_first (frame_first),
		.line_last   (line_last)
	);

	////////////////////
	// Layer trackers
	////////////////////

	layer_window win0 (
		.clk       (clk),
		.resetn    (resetn),
		.advance   (advance),
		.col       (col),
		.row       (row),
		.win_left  (s0_left),
		.win_top   (s0_top),
		.win_width (s0_width),
		.win_height(s0_height),
		.s_valid   (s0_valid),
		.s_data    (s0_data),
		.s_user    (s0_user),
		.s_last    (s0_last),
		.s_ready   (s0_ready),
		.need      (need0),
		.pix_valid (pix_valid0),
		.pix_data  (pix0)
	);

	// Grey layers ride in the low byte
	layer_window win1 (
		.clk       (clk),
		.resetn    (resetn),
		.advance   (advance),
		.col       (col),
		.row       (row),
		.win_left  (s1_left),
		.win_top   (s1_top),
		.win_width (s1_width),
		.win_height(s1_height),
		.s_valid   (s1_valid),
		.s_data    ({{PAD{1'b0}}, s1_data}),
		.s_user    (s1_user),
		.s_last    (s1_last),
		.s_ready   (s1_ready),
		.need      (need1),
		.pix_valid (pix_valid1),
		.pix_data  (pix1)
	);

	layer_window win2 (
		.clk       (clk),
		.resetn    (resetn),
		.advance   (advance),
		.col       (col),
		.row       (row),
		.win_left  (s2_left),
		.win_top   (s2_top),
		.win_width (s2_width),
		.win_height(s2_height),
		.s_valid   (s2_valid),
		.s_data    ({{PAD{1'b0}}, s2_data}),
		.s_user    (s2_user),
		.s_last    (s2_last),
		.s_ready   (s2_ready),
		.need      (need2),
		.pix_valid (pix_valid2),
		.pix_data  (pix2)
	);

	alpha_mixer mixer (
		.clk        (clk),
		.resetn     (resetn),
		.advance    (advance),
		.order      (order),
		.frame_first(frame_first),
		.line_last  (line_last),
		.base_data  (pix0),
		.ovl1_need  (need1),
		.ovl2_need  (need2),
		.ovl1_data  (pix1[`BLEND_OVL_WIDTH-1:0]),
		.ovl2_data  (pix2[`BLEND_OVL_WIDTH-1:0]),
		.out_ready  (out_ready),
		.out_valid  (out_valid),
		.out_user   (out_user),
		.out_last   (out_last),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

//--- sim/tb_layer_blender.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_settings.svh"

module tb_layer_blender
	import blend_pkg::*;
();

	localparam int NUM_CASES = 6;
	localparam int TIMEOUT   = 2000;

	// One row of the case table, first field in the top byte
	typedef struct packed {
		logic [7:0] fw;
		logic [7:0] fh;
		logic [7:0] l1;
		logic [7:0] t1;
		logic [7:0] w1;
		logic [7:0] h1;
		logic [7:0] l2;
		logic [7:0] t2;
		logic [7:0] w2;
		logic [7:0] h2;
		logic [7:0] order_sel;
		logic [7:0] ready_pct;
		logic [7:0] valid_pct;
		logic [7:0] junk;
	} frame_case_t;

	logic clk;
	logic resetn;
	ovl_order_t order;
	logic [`BLEND_WBITS-1:0] frame_width;
	logic [`BLEND_HBITS-1:0] frame_height;
	logic s0_valid;
	logic [`BLEND_BASE_WIDTH-1:0] s0_data;
	logic s0_user;
	logic s0_last;
	logic s0_ready;
	logic [`BLEND_WBITS-1:0] s0_left;
	logic [`BLEND_HBITS-1:0] s0_top;
	logic [`BLEND_WBITS-1:0] s0_width;
	logic [`BLEND_HBITS-1:0] s0_height;
	logic s1_valid;
	logic [`BLEND_OVL_WIDTH-1:0] s1_data;
	logic s1_user;
	logic s1_last;
	logic s1_ready;
	logic [`BLEND_WBITS-1:0] s1_left;
	logic [`BLEND_HBITS-1:0] s1_top;
	logic [`BLEND_WBITS-1:0] s1_width;
	logic [`BLEND_HBITS-1:0] s1_height;
	logic s2_valid;
	logic [`BLEND_OVL_WIDTH-1:0] s2_data;
	logic s2_user;
	logic s2_last;
	logic s2_ready;
	logic [`BLEND_WBITS-1:0] s2_left;
	logic [`BLEND_HBITS-1:0] s2_top;
	logic [`BLEND_WBITS-1:0] s2_width;
	logic [`BLEND_HBITS-1:0] s2_height;
	logic out_valid;
	logic [`BLEND_OUT_WIDTH-1:0] out_data;
	logic out_user;
	logic out_last;
	logic out_ready;

	frame_case_t cases [0:NUM_CASES-1];
	frame_case_t fc;
	// Two frames of source pixels per case
	logic [31:0] base_px [0:95];
	logic [7:0] ovl_px [1:2][0:95];
	int seed;
	int error_count;
	int timeout_count;
	int cur_case;
	int cur_beat;

	layer_blender uut (.*);

	always #10 clk = ~clk;

	////////////////////
	// Reporting
	////////////////////

	task automatic finish_run();
		$display("Errors: %0d check, %0d timeout", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	task automatic give_up(input string what);
		$display("Timeout in case %0d: %s made no progress", cur_case, what);
		timeout_count++;
		finish_run();
	endtask

	task automatic check_pixel(
		input string name,
		input logic [`BLEND_OUT_WIDTH-1:0] got,
		input logic [`BLEND_OUT_WIDTH-1:0] exp
	);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h (case %0d, beat %0d)",
				name, got, exp, cur_case, cur_beat);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h (case %0d, beat %0d)",
				name, got, exp, cur_case, cur_beat);
			error_count++;
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [7:0] mix_channel(input int c, input int g, input int a);
		if (g > c) begin
			return c + ((g - c) * a) / 256;
		end
		return c - ((c - g) * a) / 256;
	endfunction

	function automatic bit covers(input int c, input int r, input int l, input int t,
		input int w, input int h);
		return (c >= l) && (c < l + w) && (r >= t) && (r < t + h);
	endfunction

	function automatic logic [23:0] expected_pixel(input frame_case_t f_case, input int f,
		input int r, input int c);
		logic [31:0] base;
		bit in1;
		bit in2;
		int g;
		int a;
		base = base_px[f * f_case.fw * f_case.fh + r * f_case.fw + c];
		in1 = covers(c, r, f_case.l1, f_case.t1, f_case.w1, f_case.h1);
		in2 = covers(c, r, f_case.l2, f_case.t2, f_case.w2, f_case.h2);
		if (!in1 && !in2) begin
			return base[23:0];
		end
		if (in1 && (!in2 || f_case.order_sel == 0)) begin
			g = ovl_px[1][f * f_case.w1 * f_case.h1 + (r - f_case.t1) * f_case.w1
				+ (c - f_case.l1)];
		end else begin
			g = ovl_px[2][f * f_case.w2 * f_case.h2 + (r - f_case.t2) * f_case.w2
				+ (c - f_case.l2)];
		end
		a = base[31:24];
		return {mix_channel(base[23:16], g, a), mix_channel(base[15:8], g, a),
			mix_channel(base[7:0], g, a)};
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	task automatic apply_case(input frame_case_t f_case);
		frame_width  <= f_case.fw;
		frame_height <= f_case.fh;
		// Base layer always spans the frame
		s0_left   <= '0;
		s0_top    <= '0;
		s0_width  <= f_case.fw;
		s0_height <= f_case.fh;
		s1_left   <= f_case.l1;
		s1_top    <= f_case.t1;
		s1_width  <= f_case.w1;
		s1_height <= f_case.h1;
		s2_left   <= f_case.l2;
		s2_top    <= f_case.t2;
		s2_width  <= f_case.w2;
		s2_height <= f_case.h2;
		order <= f_case.order_sel[0] ? ORDER_2_OVER_1 : ORDER_1_OVER_2;
	endtask

	task automatic make_frames(input frame_case_t f_case);
		int i;
		for (i = 0; i < 2 * f_case.fw * f_case.fh; i++) begin
			base_px[i] = $random(seed);
			// Pin some alphas to the ends of the range
			if (i % 5 == 1) begin
				base_px[i][31:24] = 8'h00;
			end else if (i % 5 == 3) begin
				base_px[i][31:24] = 8'hff;
			end
		end
		for (i = 0; i < 96; i++) begin
			ovl_px[1][i] = $random(seed);
			ovl_px[2][i] = $random(seed);
		end
	endtask

	function automatic logic layer_ready(input int layer);
		case (layer)
			0: return s0_ready;
			1: return s1_ready;
			default: return s2_ready;
		endcase
	endfunction

	task automatic put_pixel(input int layer, input logic valid, input logic [31:0] data,
		input logic user, input logic last);
		case (layer)
			0: begin
				s0_valid <= valid;
				s0_data  <= data;
				s0_user  <= user;
				s0_last  <= last;
			end
			1: begin
				s1_valid <= valid;
				s1_data  <= data[7:0];
				s1_user  <= user;
				s1_last  <= last;
			end
			default: begin
				s2_valid <= valid;
				s2_data  <= data[7:0];
				s2_user  <= user;
				s2_last  <= last;
			end
		endcase
	endtask

	// Sends junk, then two frames of window pixels with random gaps
	task automatic drive_layer(input int layer, input int width, input int count,
		input int junk, input int valid_pct);
		int k;
		int idle;
		logic showing;
		logic [31:0] data;
		logic user;
		logic last;
		k = -junk;
		idle = 0;
		showing = 1'b0;
		data = '0;
		user = 1'b0;
		last = 1'b0;
		while (k < count) begin
			@(posedge clk);
			if (showing && layer_ready(layer)) begin
				k++;
				idle = 0;
				showing = 1'b0;
			end else begin
				idle++;
			end
			if (idle > TIMEOUT) begin
				give_up($sformatf("layer %0d stream", layer));
			end
			if (!showing && k < count) begin
				showing = ({$random(seed)} % 100) < valid_pct;
				if (showing && k < 0) begin
					data = $random(seed);
					user = 1'b0;
					last = 1'b0;
				end else if (showing) begin
					data = (layer == 0) ? base_px[k] : {24'h0, ovl_px[layer][k]};
					user = (k % (count / 2)) == 0;
					last = (k % width) == width - 1;
				end
			end
			put_pixel(layer, showing, data, user, last);
		end
	endtask

	////////////////////
	// Output side
	////////////////////

	task automatic collect_beats(input frame_case_t f_case);
		int n;
		int idle;
		int f;
		int r;
		int c;
		n = 0;
		idle = 0;
		while (n < 2 * f_case.fw * f_case.fh) begin
			@(posedge clk);
			if (out_valid && out_ready) begin
				cur_beat = n;
				f = n / (f_case.fw * f_case.fh);
				r = (n % (f_case.fw * f_case.fh)) / f_case.fw;
				c = n % f_case.fw;
				check_pixel("out_data", out_data, expected_pixel(f_case, f, r, c));
				check_flag("out_user", out_user, (r == 0) && (c == 0));
				check_flag("out_last", out_last, c == f_case.fw - 1);
				n++;
				idle = 0;
			end else begin
				idle++;
			end
			if (idle > TIMEOUT) begin
				give_up("output stream");
			end
			out_ready <= ({$random(seed)} % 100) < f_case.ready_pct;
		end
		out_ready <= 1'b0;
	endtask

	// Nothing may follow the last beat of a case
	task automatic check_no_extra_beats();
		int i;
		for (i = 0; i < 4; i++) begin
			@(posedge clk);
			if (out_valid && out_ready) begin
				$display("Extra output beat after the end of case %0d", cur_case);
				error_count++;
			end
			out_ready <= 1'b1;
		end
		out_ready <= 1'b0;
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int i;
		seed = 32'h65da3cd7;
		error_count = 0;
		timeout_count = 0;
		cur_case = 0;
		cur_beat = 0;
		clk = 1'b0;
		resetn = 1'b0;
		order = ORDER_1_OVER_2;
		out_ready = 1'b0;
		fc = '0;
		apply_case(fc);
		put_pixel(0, 1'b0, '0, 1'b0, 1'b0);
		put_pixel(1, 1'b0, '0, 1'b0, 1'b0);
		put_pixel(2, 1'b0, '0, 1'b0, 1'b0);

		// fw fh | l1 t1 w1 h1 | l2 t2 w2 h2 | order ready% valid% junk
		cases[0] = {8'd8, 8'd6, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0,
			8'd0, 8'd100, 8'd100, 8'd3};
		cases[1] = {8'd8, 8'd6, 8'd2, 8'd1, 8'd4, 8'd3, 8'd0, 8'd0, 8'd0, 8'd0,
			8'd0, 8'd70, 8'd80, 8'd0};
		cases[2] = {8'd8, 8'd6, 8'd1, 8'd1, 8'd5, 8'd4, 8'd3, 8'd2, 8'd4, 8'd3,
			8'd0, 8'd60, 8'd60, 8'd0};
		cases[3] = {8'd8, 8'd6, 8'd1, 8'd1, 8'd5, 8'd4, 8'd3, 8'd2, 8'd4, 8'd3,
			8'd1, 8'd50, 8'd70, 8'd0};
		cases[4] = {8'd5, 8'd3, 8'd0, 8'd0, 8'd5, 8'd3, 8'd4, 8'd2, 8'd1, 8'd1,
			8'd1, 8'd40, 8'd50, 8'd0};
		cases[5] = {8'd3, 8'd2, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd1, 8'd3, 8'd1,
			8'd0, 8'd100, 8'd30, 8'd0};

		// Handshake outputs stay low while reset is held
		@(posedge clk);
		for (i = 0; i < 4; i++) begin
			@(posedge clk);
			check_flag("out_valid", out_valid, 1'b0);
			check_flag("out_user", out_user, 1'b0);
			check_flag("out_last", out_last, 1'b0);
			check_flag("s0_ready", s0_ready, 1'b0);
			check_flag("s1_ready", s1_ready, 1'b0);
			check_flag("s2_ready", s2_ready, 1'b0);
		end
		resetn <= 1'b1;

		for (i = 0; i < NUM_CASES; i++) begin
			fc = cases[i];
			cur_case = i;
			@(posedge clk);
			apply_case(fc);
			make_frames(fc);
			fork
				drive_layer(0, fc.fw, 2 * fc.fw * fc.fh, fc.junk, fc.valid_pct);
				drive_layer(1, fc.w1, 2 * fc.w1 * fc.h1, fc.junk, fc.valid_pct);
				drive_layer(2, fc.w2, 2 * fc.w2 * fc.h2, fc.junk, fc.valid_pct);
				collect_beats(fc);
			join
			check_no_extra_beats();
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/blend_pkg.sv
src/frame_scanner.sv
src/layer_window.sv
src/alpha_mixer.sv
src/layer_blender.sv
sim/tb_layer_blender.sv
